// File: common/dmem_pkg.sv
`default_nettype none

package dmem_pkg;

    // access width of a core request
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } access_size_e;

    // core-side request, wdata in the low bytes
    typedef struct packed {
        logic         valid;
        logic         wen;
        access_size_e size;
        logic [31:0]  addr;   // any byte address
        logic [31:0]  wdata;
    } dmem_req_t;

    // core-side response, one-cycle pulse
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;    // echo of the request address
        logic [31:0] rdata;   // four bytes from addr upward
    } dmem_resp_t;

    // word memory request
    typedef struct packed {
        logic        valid;
        logic        wen;
        logic [31:0] addr;    // word aligned
        logic [31:0] wdata;
    } mem_req_t;

    // word memory read response
    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } mem_resp_t;

    localparam int RAM_WORDS  = 256;                 // depth in words
    localparam int RAM_WAIT   = 2;                   // cycles from valid to ready
    localparam int RAM_IDX_W  = $clog2(RAM_WORDS);   // word index width
    localparam int RAM_WAIT_W = $clog2(RAM_WAIT + 1);

endpackage

`default_nettype wire

// File: dmem_access/dmem_lane_merge.sv
`default_nettype none

module dmem_lane_merge (
    input  dmem_pkg::access_size_e size,
    input  logic [1:0]             offset,
    input  logic [31:0]            wdata,
    input  logic [31:0]            rdata1,
    input  logic [31:0]            rdata2,
    output logic [31:0]            load_data,
    output logic [31:0]            store_word1,
    output logic [31:0]            store_word2
);
    import dmem_pkg::*;

    logic [63:0] old_pair;        // second word above first word
    logic [63:0] new_pair;
    logic [63:0] wdata_shifted;
    logic [63:0] load_pair;
    logic [7:0]  byte_en;
    logic [3:0]  size_mask;
    logic [4:0]  shift_bits;

    assign old_pair   = {rdata2, rdata1};
    assign shift_bits = {offset, 3'b000};   // offset in bits

    // bytes written from the access address upward
    always_comb begin
        case (size)
            SIZE_B:  size_mask = 4'b0001;
            SIZE_H:  size_mask = 4'b0011;
            default: size_mask = 4'b1111;
        endcase
    end

    // lanes of both words touched by the store
    assign byte_en       = {4'b0000, size_mask} << offset;
    assign wdata_shifted = {32'd0, wdata} << shift_bits;

    // byte-wise merge of new data over the old words
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            if (byte_en[i]) begin
                new_pair[8*i +: 8] = wdata_shifted[8*i +: 8];
            end else begin
                new_pair[8*i +: 8] = old_pair[8*i +: 8];
            end
        end
    end

    /*
     * a load returns the four bytes starting at the address,
     * so the pair is shifted down by the byte offset
     */
    assign load_pair = old_pair >> shift_bits;
    assign load_data = load_pair[31:0];

    assign store_word1 = new_pair[31:0];
    assign store_word2 = new_pair[63:32];   // only written when the access spills

endmodule

`default_nettype wire

// File: dmem_access/dmem_access_ctrl.sv
`default_nettype none

module dmem_access_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  dmem_pkg::dmem_req_t  req,
    output logic                 req_ready,
    output dmem_pkg::dmem_resp_t resp,
    output dmem_pkg::mem_req_t   mem_req,
    input  logic                 mem_ready,
    input  dmem_pkg::mem_resp_t  mem_resp
);
    import dmem_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        S_STORE_CHECK,
        S_RD1_REQ,
        S_RD1_WAIT,
        S_RD2_REQ,
        S_RD2_WAIT,
        S_MERGE,
        S_RESP,
        S_WR1,
        S_WR2
    } state_e;

    state_e      state;
    dmem_req_t   sreq;          // latched core request
    logic [31:0] saved_rdata1;
    logic [31:0] saved_rdata2;
    logic [31:0] load_result;
    logic [31:0] store_wdata1;
    logic [31:0] store_wdata2;
    logic [31:0] load_data;
    logic [31:0] store_word1;
    logic [31:0] store_word2;
    logic [31:0] addr_aligned;
    logic [1:0]  offset;
    logic        need_read;
    logic        need_second;
    logic        first_word;

    assign offset       = sreq.addr[1:0];
    assign addr_aligned = {sreq.addr[31:2], 2'b00};

    // only an aligned word store skips the read
    assign need_read   = !(sreq.size == SIZE_W && offset == 2'd0);
    // access spills into the next word
    assign need_second = (sreq.size == SIZE_W && offset != 2'd0) ||
                         (sreq.size == SIZE_H && offset == 2'd3);

    dmem_lane_merge u_lane_merge (
        .size        (sreq.size),
        .offset      (offset),
        .wdata       (sreq.wdata),
        .rdata1      (saved_rdata1),
        .rdata2      (saved_rdata2),
        .load_data   (load_data),
        .store_word1 (store_word1),
        .store_word2 (store_word2)
    );

    assign first_word = state == S_RD1_REQ || state == S_WR1;

    assign req_ready     = state == S_IDLE;
    assign resp.valid    = state == S_RESP;
    assign resp.addr     = sreq.addr;
    assign resp.rdata    = load_result;
    assign mem_req.valid = state == S_RD1_REQ || state == S_RD2_REQ ||
                           state == S_WR1 || state == S_WR2;
    assign mem_req.wen   = state == S_WR1 || state == S_WR2;
    assign mem_req.addr  = first_word ? addr_aligned : addr_aligned + 32'd4;
    assign mem_req.wdata = state == S_WR2 ? store_wdata2 : store_wdata1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req.valid) begin
                        state <= req.wen ? S_STORE_CHECK : S_RD1_REQ;
                    end
                end
                S_STORE_CHECK: state <= need_read ? S_RD1_REQ : S_WR1;
                S_RD1_REQ:     if (mem_ready) state <= S_RD1_WAIT;
                S_RD1_WAIT: begin
                    if (mem_resp.valid) begin
                        state <= need_second ? S_RD2_REQ : S_MERGE;
                    end
                end
                S_RD2_REQ:     if (mem_ready) state <= S_RD2_WAIT;
                S_RD2_WAIT:    if (mem_resp.valid) state <= S_MERGE;
                S_MERGE:       state <= sreq.wen ? S_WR1 : S_RESP;
                S_RESP:        state <= S_IDLE;
                S_WR1: begin
                    if (mem_ready) begin
                        state <= need_second ? S_WR2 : S_IDLE;
                    end
                end
                S_WR2:         if (mem_ready) state <= S_IDLE;
                default:       state <= S_IDLE;
            endcase
        end
    end

    // request latch and data path registers
    always_ff @(posedge clk) begin
        if (state == S_IDLE && req.valid) begin
            sreq <= req;
        end
        if (state == S_STORE_CHECK) begin
            store_wdata1 <= store_word1;   // aligned word passes wdata through
        end
        if (state == S_RD1_WAIT && mem_resp.valid) begin
            saved_rdata1 <= mem_resp.rdata;
        end
        if (state == S_RD2_WAIT && mem_resp.valid) begin
            saved_rdata2 <= mem_resp.rdata;
        end
        if (state == S_MERGE) begin
            load_result  <= load_data;
            store_wdata1 <= store_word1;
            store_wdata2 <= store_word2;
        end
    end

    a_mem_addr_aligned: assert property (@(posedge clk) disable iff (rst)
        mem_req.valid |-> mem_req.addr[1:0] == 2'b00);

    // memory side must not change a pending access
    a_mem_req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req.valid && !mem_ready |=> $stable(mem_req));

    a_resp_single_pulse: assert property (@(posedge clk) disable iff (rst)
        resp.valid |=> !resp.valid);

endmodule

`default_nettype wire

// File: rtl/dmem_word_ram.sv
`default_nettype none

module dmem_word_ram (
    input  logic                clk,
    input  logic                rst,
    input  dmem_pkg::mem_req_t  mem_req,
    output logic                mem_ready,
    output dmem_pkg::mem_resp_t mem_resp
);
    import dmem_pkg::*;

    logic [31:0]           mem [RAM_WORDS];
    logic [RAM_WAIT_W-1:0] wait_cnt;
    logic [RAM_IDX_W-1:0]  word_idx;
    logic                  accept;
    logic                  resp_valid;
    logic [31:0]           resp_rdata;

    assign word_idx = mem_req.addr[RAM_IDX_W+1:2];   // drop byte offset
    assign accept   = mem_req.valid && mem_ready;

    // ready after RAM_WAIT cycles, dropped after the accepting edge
    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt  <= '0;
            mem_ready <= 1'b0;
        end else if (accept) begin
            wait_cnt  <= '0;
            mem_ready <= 1'b0;
        end else if (mem_req.valid && !mem_ready) begin
            if (wait_cnt == RAM_WAIT_W'(RAM_WAIT - 1)) begin
                mem_ready <= 1'b1;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end else if (!mem_req.valid) begin
            wait_cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= accept && !mem_req.wen;   // reads only
        end
    end

    always_ff @(posedge clk) begin
        if (accept && mem_req.wen) begin
            mem[word_idx] <= mem_req.wdata;
        end
        if (accept && !mem_req.wen) begin
            resp_rdata <= mem[word_idx];
        end
    end

    assign mem_resp.valid = resp_valid;
    assign mem_resp.rdata = resp_rdata;

    a_addr_in_range: assert property (@(posedge clk) disable iff (rst)
        accept |-> (mem_req.addr >> 2) < 32'(RAM_WORDS));

endmodule

`default_nettype wire

// File: rtl/dmem_subsystem.sv
`default_nettype none

module dmem_subsystem (
    input  logic                 clk,
    input  logic                 rst,
    input  dmem_pkg::dmem_req_t  req,
    output logic                 req_ready,
    output dmem_pkg::dmem_resp_t resp
);
    import dmem_pkg::*;

    mem_req_t  mem_req;     // controller to RAM
    logic      mem_ready;
    mem_resp_t mem_resp;

    dmem_access_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_ready (req_ready),
        .resp      (resp),
        .mem_req   (mem_req),
        .mem_ready (mem_ready),
        .mem_resp  (mem_resp)
    );

    dmem_word_ram u_ram (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_ready (mem_ready),
        .mem_resp  (mem_resp)
    );

endmodule

`default_nettype wire

// File: tb/tb_dmem_model.svh
// shadow copy of the word memory, one entry per byte
logic [7:0] shadow [RAM_WORDS*4];

// four bytes starting at addr, lowest address in the low byte
function automatic logic [31:0] read_shadow(input logic [31:0] addr);
    logic [31:0] byte_addr;
    logic [31:0] data;
    for (int i = 0; i < 4; i++) begin
        byte_addr = addr + 32'(i);
        data[8*i +: 8] = shadow[byte_addr[RAM_IDX_W+1:0]];
    end
    return data;
endfunction

// response bytes that come from words actually read
function automatic logic [31:0] loaded_byte_mask(input access_size_e size,
                                                 input logic [1:0] offset);
    int          words;
    logic [31:0] mask;
    words = ((size == SIZE_W && offset != 2'd0) || (size == SIZE_H && offset == 2'd3)) ? 2 : 1;
    mask = '0;
    for (int i = 0; i < 4; i++) begin
        if (int'(offset) + i < 4 * words) begin
            mask[8*i +: 8] = 8'hff;
        end
    end
    return mask;
endfunction

// initial contents, differs for every word address
function automatic logic [31:0] fill_value(input logic [31:0] addr);
    return (addr * 32'h9e3779b1) ^ 32'h3c5a96e1;
endfunction

// hold the request until the controller takes it
task automatic send_request(input logic wen, input access_size_e size,
                            input logic [31:0] addr, input logic [31:0] wdata);
    dmem_req_t r;
    logic      accepted;
    r.valid  = 1'b1;
    r.wen    = wen;
    r.size   = size;
    r.addr   = addr;
    r.wdata  = wdata;
    accepted = 1'b0;
    @(posedge clk);
    req <= r;
    while (!accepted) begin
        @(negedge clk);
        accepted = req_ready;   // taken on the next rising edge
        @(posedge clk);
    end
    req <= '0;
endtask

task automatic store_at(input access_size_e size, input logic [31:0] addr,
                        input logic [31:0] data);
    int          n;
    logic [31:0] byte_addr;
    n = (size == SIZE_B) ? 1 : (size == SIZE_H) ? 2 : 4;
    for (int i = 0; i < n; i++) begin
        byte_addr = addr + 32'(i);
        shadow[byte_addr[RAM_IDX_W+1:0]] = data[8*i +: 8];
    end
    send_request(1'b1, size, addr, data);
    store_count++;
endtask

task automatic load_at(input access_size_e size, input logic [31:0] addr);
    logic seen;
    exp_addr     = addr;
    exp_rdata    = read_shadow(addr);
    exp_mask     = loaded_byte_mask(size, addr[1:0]);
    resp_pending = 1'b1;
    send_request(1'b0, size, addr, 32'd0);
    seen = 1'b0;
    while (!seen) begin
        @(negedge clk);
        seen = resp.valid;
    end
    @(posedge clk);
    resp_pending = 1'b0;   // a second pulse now trips the check
    load_count++;
endtask

// File: tb/tb_dmem.sv
`default_nettype none

module tb_dmem;
    import dmem_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 8;
    localparam int WINDOW_WORDS   = 16;                       // filled area for later tests
    localparam int RANDOM_BYTES   = (WINDOW_WORDS - 1) * 4;   // second word stays in window
    localparam int N_RANDOM       = 120;
    localparam int N_ACCESSES     = 16 + WINDOW_WORDS + 16 + 12 + N_RANDOM;
    localparam int ACCESS_CYCLES  = 4 * (RAM_WAIT + 1) + 10;  // crossing store plus gaps
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_ACCESSES * ACCESS_CYCLES + 50;

    logic        clk;
    logic        rst;
    dmem_req_t   req;
    logic        req_ready;
    dmem_resp_t  resp;
    logic        resp_pending;   // load waiting for its response
    logic [31:0] exp_addr;
    logic [31:0] exp_rdata;
    logic [31:0] exp_mask;
    int          error_count;
    int          load_count;
    int          store_count;
    int          cycle_count;
    integer      seed;

    dmem_subsystem dut (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_ready (req_ready),
        .resp      (resp)
    );

    `include "tb_dmem_model.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d, loads checked: %0d", error_count, load_count);
            $display("Finished with errors");
            $finish;
        end
    end

    a_reset_ready: assert property (@(posedge clk) $fell(rst) |-> req_ready)
        else begin
            $display("[ERROR] req_ready after reset: expected 1, got %h", req_ready);
            error_count++;
        end

    a_reset_quiet: assert property (@(posedge clk) $fell(rst) |-> !resp.valid)
        else begin
            $display("[ERROR] resp.valid after reset: expected 0, got %h", resp.valid);
            error_count++;
        end

    a_resp_expected: assert property (@(posedge clk) disable iff (rst)
        resp.valid |-> resp_pending)
        else begin
            $display("response pulse with no load waiting, address %h", resp.addr);
            error_count++;
        end

    a_resp_addr: assert property (@(posedge clk) disable iff (rst)
        resp.valid |-> resp.addr == exp_addr)
        else begin
            $display("[ERROR] resp.addr: expected %h, got %h", exp_addr, resp.addr);
            error_count++;
        end

    a_resp_rdata: assert property (@(posedge clk) disable iff (rst)
        resp.valid |-> (resp.rdata & exp_mask) == (exp_rdata & exp_mask))
        else begin
            $display("[ERROR] resp.rdata at %h: expected %h, got %h (mask %h)",
                     exp_addr, exp_rdata, resp.rdata, exp_mask);
            error_count++;
        end

    initial begin
        logic [31:0]  addr;
        logic [31:0]  rnd;
        access_size_e size;
        rst          = 1'b1;
        req          = '0;
        resp_pending = 1'b0;
        exp_addr     = '0;
        exp_rdata    = '0;
        exp_mask     = '0;
        error_count  = 0;
        load_count   = 0;
        store_count  = 0;
        cycle_count  = 0;
        seed         = 32'h8cf0c3c0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        // aligned words outside the window
        for (int i = 0; i < 8; i++) begin
            store_at(SIZE_W, 32'h80 + 32'(4 * i), $random(seed));
        end
        for (int i = 0; i < 8; i++) begin
            load_at(SIZE_W, 32'h80 + 32'(4 * i));
        end

        for (int w = 0; w < WINDOW_WORDS; w++) begin
            store_at(SIZE_W, 32'(4 * w), fill_value(32'(4 * w)));
        end

        // narrow stores, checked by a full word load
        for (int off = 0; off < 4; off++) begin
            store_at(SIZE_B, 32'h10 + 32'(off), $random(seed));
            load_at(SIZE_W, 32'h10);
        end
        for (int off = 0; off < 4; off++) begin
            store_at(SIZE_H, 32'h14 + 32'(off), $random(seed));
            load_at(SIZE_W, 32'h14);
        end

        // accesses that spill into the next word
        for (int off = 1; off < 4; off++) begin
            store_at(SIZE_W, 32'h20 + 32'(off), $random(seed));
            load_at(SIZE_W, 32'h20 + 32'(off));
            load_at(SIZE_W, 32'h24);
        end
        store_at(SIZE_H, 32'h2b, $random(seed));
        load_at(SIZE_H, 32'h2b);
        load_at(SIZE_W, 32'h2c);

        for (int n = 0; n < N_RANDOM; n++) begin
            rnd  = $random(seed);
            addr = $unsigned($random(seed)) % RANDOM_BYTES;
            size = access_size_e'(rnd[1:0] % 2'd3);
            if (rnd[8]) begin
                store_at(size, addr, $random(seed));
            end else begin
                load_at(size, addr);
            end
        end

        @(negedge clk);
        while (!req_ready) begin   // last store still writing
            @(negedge clk);
        end
        repeat (4) @(posedge clk);
        $display("errors: %0d, loads checked: %0d, stores: %0d",
                 error_count, load_count, store_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+tb
common/dmem_pkg.sv
dmem_access/dmem_lane_merge.sv
dmem_access/dmem_access_ctrl.sv
rtl/dmem_word_ram.sv
rtl/dmem_subsystem.sv
tb/tb_dmem.sv

// File: Makefile
BIN  := obj_dir/Vtb_dmem
SRCS := $(shell grep -v '^+' verilog.f) tb/tb_dmem_model.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) verilog.f
	verilator --binary --timing --assert -f verilog.f --top-module tb_dmem

run: $(BIN)
	./$(BIN) > sim.log 2>&1; cat sim.log
	@if grep -q "Finished with errors" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" sim.log || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
